//--- common/disp_consts.svh
// Sizes and field widths of the warp dispatch stage
// Shared by the package and the dispatch RTL

`ifndef DISP_CONSTS_SVH
`define DISP_CONSTS_SVH

// Warps served by one dispatch stage
`define NUM_WARPS 4

// In-flight instructions allowed per warp
`define NUM_TAGS 4

// Instruction buffer entries per warp
`define IB_DEPTH 2

// Payload field widths
`define PC_WIDTH 16
`define WARP_WIDTH 8
`define REG_IDX_WIDTH 5
`define INST_WIDTH 16

// Source operands per instruction
`define NUM_OPERANDS 2

`endif

//--- common/disp_pkg.sv
// Shared types of the warp dispatch stage
// Id widths, payload fields and the dispatch entry struct

`include "disp_consts.svh"

package disp_pkg;

    // Derived id widths
    localparam int unsigned WidWidth = (`NUM_WARPS > 1) ? $clog2(`NUM_WARPS) : 1;
    localparam int unsigned TagWidth = (`NUM_TAGS > 1) ? $clog2(`NUM_TAGS) : 1;

    typedef logic [WidWidth-1:0] wid_t;
    typedef logic [TagWidth-1:0] tag_t;

    // Global instruction id, tag in the upper bits and warp id below
    typedef logic [TagWidth+WidWidth-1:0] iid_t;

    // Payload fields
    typedef logic [`PC_WIDTH-1:0]      pc_t;
    typedef logic [`WARP_WIDTH-1:0]    act_mask_t;
    typedef logic [`INST_WIDTH-1:0]    inst_t;
    typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;

    typedef reg_idx_t [`NUM_OPERANDS-1:0] op_reg_idx_t;
    typedef logic [`NUM_OPERANDS-1:0]     op_is_reg_t;

    // One instruction leaving a warp dispatcher towards the arbiter
    typedef struct packed {
        tag_t        tag;
        pc_t         pc;
        act_mask_t   act_mask;
        inst_t       inst;
        reg_idx_t    dst_reg;
        op_is_reg_t  operands_is_reg;
        op_reg_idx_t operands;
    } disp_entry_t;

endpackage

//--- dispatcher/warp_dispatcher.sv
// Per-warp dispatcher
// In-order instruction buffer, destination scoreboard and tag pool

`include "disp_consts.svh"

module warp_dispatcher (
    input  logic                    clk_i,
    input  logic                    rst_i,

    // From decoder
    input  logic                    dec_valid_i,
    input  disp_pkg::pc_t           dec_pc_i,
    input  disp_pkg::act_mask_t     dec_act_mask_i,
    input  disp_pkg::inst_t         dec_inst_i,
    input  disp_pkg::reg_idx_t      dec_dst_i,
    input  disp_pkg::op_is_reg_t    dec_operands_is_reg_i,
    input  disp_pkg::op_reg_idx_t   dec_operands_i,
    output logic                    ib_ready_o,

    // To arbiter
    output logic                    disp_ready_o,
    output disp_pkg::disp_entry_t   disp_entry_o,
    input  logic                    disp_grant_i,

    // Writeback
    input  logic                    eu_valid_i,
    input  disp_pkg::tag_t          eu_tag_i,

    output logic                    all_finished_o
);
    import disp_pkg::*;

    localparam int unsigned PtrWidth = (`IB_DEPTH > 1) ? $clog2(`IB_DEPTH) : 1;
    localparam int unsigned CntWidth = $clog2(`IB_DEPTH + 1);

    // ##################################################################
    // Instruction buffer
    // ##################################################################

    pc_t         ib_pc_q     [`IB_DEPTH];
    act_mask_t   ib_mask_q   [`IB_DEPTH];
    inst_t       ib_inst_q   [`IB_DEPTH];
    reg_idx_t    ib_dst_q    [`IB_DEPTH];
    op_is_reg_t  ib_is_reg_q [`IB_DEPTH];
    op_reg_idx_t ib_ops_q    [`IB_DEPTH];

    logic [PtrWidth-1:0] rd_ptr_q, wr_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic push, pop;

    assign ib_ready_o = (count_q != CntWidth'(`IB_DEPTH));
    assign push       = dec_valid_i && ib_ready_o;
    // Arbiter grants only warps that raised disp_ready_o
    assign pop        = disp_grant_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(`IB_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(`IB_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            ib_pc_q[wr_ptr_q]     <= dec_pc_i;
            ib_mask_q[wr_ptr_q]   <= dec_act_mask_i;
            ib_inst_q[wr_ptr_q]   <= dec_inst_i;
            ib_dst_q[wr_ptr_q]    <= dec_dst_i;
            ib_is_reg_q[wr_ptr_q] <= dec_operands_is_reg_i;
            ib_ops_q[wr_ptr_q]    <= dec_operands_i;
        end
    end

    // ##################################################################
    // Scoreboard and tag pool
    // ##################################################################

    logic [`NUM_TAGS-1:0] tag_free_q;
    reg_idx_t             tag_dst_q [`NUM_TAGS];
    logic                 tag_avail;
    tag_t                 alloc_tag;
    logic                 hazard;

    // Lowest free tag wins
    always_comb begin
        tag_avail = 1'b0;
        alloc_tag = '0;
        for (int t = `NUM_TAGS - 1; t >= 0; t--) begin
            if (tag_free_q[t]) begin
                tag_avail = 1'b1;
                alloc_tag = tag_t'(t);
            end
        end
    end

    // Head against every in-flight destination, WAW and RAW
    always_comb begin
        hazard = 1'b0;
        for (int t = 0; t < `NUM_TAGS; t++) begin
            if (!tag_free_q[t]) begin
                if (tag_dst_q[t] == ib_dst_q[rd_ptr_q]) begin
                    hazard = 1'b1;
                end
                for (int op = 0; op < `NUM_OPERANDS; op++) begin
                    if (ib_is_reg_q[rd_ptr_q][op]
                        && (ib_ops_q[rd_ptr_q][op] == tag_dst_q[t])) begin
                        hazard = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tag_free_q <= '1;
        end else begin
            if (eu_valid_i) begin
                tag_free_q[eu_tag_i] <= 1'b1;
            end
            if (pop) begin
                tag_free_q[alloc_tag] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            tag_dst_q[alloc_tag] <= ib_dst_q[rd_ptr_q];
        end
    end

    // Outputs
    assign disp_ready_o   = (count_q != '0) && tag_avail && !hazard;
    assign all_finished_o = (count_q == '0) && (&tag_free_q);

    assign disp_entry_o.tag             = alloc_tag;
    assign disp_entry_o.pc              = ib_pc_q[rd_ptr_q];
    assign disp_entry_o.act_mask        = ib_mask_q[rd_ptr_q];
    assign disp_entry_o.inst            = ib_inst_q[rd_ptr_q];
    assign disp_entry_o.dst_reg         = ib_dst_q[rd_ptr_q];
    assign disp_entry_o.operands_is_reg = ib_is_reg_q[rd_ptr_q];
    assign disp_entry_o.operands        = ib_ops_q[rd_ptr_q];

endmodule

//--- dispatcher/rr_arbiter.sv
// Round-robin arbiter with a generic payload
// Pointer advances only on an accepted transfer

module rr_arbiter #(
    parameter int unsigned NumIn     = 4,
    parameter type         payload_t = logic
) (
    input  logic               clk_i,
    input  logic               rst_i,

    input  logic [NumIn-1:0]   req_i,
    input  payload_t           data_i [NumIn],
    output logic [NumIn-1:0]   gnt_o,

    output logic               valid_o,
    output payload_t           data_o,
    output disp_pkg::wid_t     idx_o,
    input  logic               ready_i
);
    import disp_pkg::*;

    // Highest priority input for the next decision
    wid_t ptr_q;

    // First requester at or after the pointer
    always_comb begin
        int unsigned cand;
        valid_o = 1'b0;
        idx_o   = '0;
        for (int unsigned i = 0; i < NumIn; i++) begin
            cand = (int'(ptr_q) + i) % NumIn;
            if (!valid_o && req_i[cand]) begin
                valid_o = 1'b1;
                idx_o   = wid_t'(cand);
            end
        end
    end

    assign data_o = data_i[idx_o];

    // Grant doubles as the pop strobe, so only on handshake
    always_comb begin
        gnt_o = '0;
        if (valid_o && ready_i) begin
            gnt_o[idx_o] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_q <= '0;
        end else if (valid_o && ready_i) begin
            ptr_q <= (idx_o == wid_t'(NumIn - 1)) ? '0 : idx_o + 1'b1;
        end
    end

endmodule

//--- src/multi_warp_dispatcher.sv
// Issue stage top level
// Routes decoder and writeback traffic to the per-warp dispatchers
// and arbitrates one dispatch per cycle

`include "disp_consts.svh"

module multi_warp_dispatcher (
    input  logic                    clk_i,
    input  logic                    rst_i,

    // Decoder
    input  logic                    dec_valid_i,
    input  disp_pkg::wid_t          dec_warp_id_i,
    input  disp_pkg::pc_t           dec_pc_i,
    input  disp_pkg::act_mask_t     dec_act_mask_i,
    input  disp_pkg::inst_t         dec_inst_i,
    input  disp_pkg::reg_idx_t      dec_dst_i,
    input  disp_pkg::op_is_reg_t    dec_operands_is_reg_i,
    input  disp_pkg::op_reg_idx_t   dec_operands_i,
    output logic                    ib_ready_o,

    // Operand collector
    input  logic                    opc_ready_i,
    output logic                    disp_valid_o,
    output disp_pkg::iid_t          disp_tag_o,
    output disp_pkg::pc_t           disp_pc_o,
    output disp_pkg::act_mask_t     disp_act_mask_o,
    output disp_pkg::inst_t         disp_inst_o,
    output disp_pkg::reg_idx_t      disp_dst_o,
    output disp_pkg::op_is_reg_t    disp_operands_is_reg_o,
    output disp_pkg::op_reg_idx_t   disp_operands_o,

    // Execution units
    input  logic                    eu_valid_i,
    input  disp_pkg::iid_t          eu_tag_i,

    output logic [`NUM_WARPS-1:0]   ib_all_instr_finished_o
);
    import disp_pkg::*;

    logic [`NUM_WARPS-1:0] dec_valid_warp, ib_ready_warp, eu_valid_warp;
    logic [`NUM_WARPS-1:0] arb_req, arb_gnt;
    tag_t                  eu_tag;
    disp_entry_t           arb_data [`NUM_WARPS];
    disp_entry_t           arb_sel;
    wid_t                  arb_idx;

    // ##################################################################
    // Warp demultiplexing
    // ##################################################################

    always_comb begin
        dec_valid_warp = '0;
        dec_valid_warp[dec_warp_id_i] = dec_valid_i;
    end

    assign ib_ready_o = ib_ready_warp[dec_warp_id_i];

    // Low bits of the iid name the warp
    always_comb begin
        for (int w = 0; w < `NUM_WARPS; w++) begin
            eu_valid_warp[w] = eu_valid_i && (eu_tag_i[WidWidth-1:0] == wid_t'(w));
        end
    end

    assign eu_tag = eu_tag_i[WidWidth +: TagWidth];

    for (genvar w = 0; w < `NUM_WARPS; w++) begin : gen_warp
        warp_dispatcher i_warp_dispatcher (
            .clk_i                 (clk_i),
            .rst_i                 (rst_i),
            .dec_valid_i           (dec_valid_warp[w]),
            .dec_pc_i              (dec_pc_i),
            .dec_act_mask_i        (dec_act_mask_i),
            .dec_inst_i            (dec_inst_i),
            .dec_dst_i             (dec_dst_i),
            .dec_operands_is_reg_i (dec_operands_is_reg_i),
            .dec_operands_i        (dec_operands_i),
            .ib_ready_o            (ib_ready_warp[w]),
            .disp_ready_o          (arb_req[w]),
            .disp_entry_o          (arb_data[w]),
            .disp_grant_i          (arb_gnt[w]),
            .eu_valid_i            (eu_valid_warp[w]),
            .eu_tag_i              (eu_tag),
            .all_finished_o        (ib_all_instr_finished_o[w])
        );
    end : gen_warp

    // ##################################################################
    // Dispatch arbitration
    // ##################################################################

    rr_arbiter #(
        .NumIn     (`NUM_WARPS),
        .payload_t (disp_entry_t)
    ) i_rr_arbiter (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req_i   (arb_req),
        .data_i  (arb_data),
        .gnt_o   (arb_gnt),
        .valid_o (disp_valid_o),
        .data_o  (arb_sel),
        .idx_o   (arb_idx),
        .ready_i (opc_ready_i)
    );

    // Global iid is the warp-local tag above the warp id
    assign disp_tag_o             = {arb_sel.tag, arb_idx};
    assign disp_pc_o              = arb_sel.pc;
    assign disp_act_mask_o        = arb_sel.act_mask;
    assign disp_inst_o            = arb_sel.inst;
    assign disp_dst_o             = arb_sel.dst_reg;
    assign disp_operands_is_reg_o = arb_sel.operands_is_reg;
    assign disp_operands_o        = arb_sel.operands;

endmodule

//--- sim/tb_checker.sv
// Checker for the warp dispatch stage
// Models program order, in-flight tags per warp and round-robin grants

`include "disp_consts.svh"

module tb_checker (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  dec_valid_i,
    input  disp_pkg::wid_t        dec_warp_id_i,
    input  disp_pkg::pc_t         dec_pc_i,
    input  disp_pkg::act_mask_t   dec_act_mask_i,
    input  disp_pkg::inst_t       dec_inst_i,
    input  disp_pkg::reg_idx_t    dec_dst_i,
    input  disp_pkg::op_is_reg_t  dec_operands_is_reg_i,
    input  disp_pkg::op_reg_idx_t dec_operands_i,
    input  logic                  ib_ready_i,
    input  logic                  disp_valid_i,
    input  logic                  opc_ready_i,
    input  disp_pkg::iid_t        disp_tag_i,
    input  disp_pkg::pc_t         disp_pc_i,
    input  disp_pkg::act_mask_t   disp_act_mask_i,
    input  disp_pkg::inst_t       disp_inst_i,
    input  disp_pkg::reg_idx_t    disp_dst_i,
    input  disp_pkg::op_is_reg_t  disp_operands_is_reg_i,
    input  disp_pkg::op_reg_idx_t disp_operands_i,
    input  logic                  eu_valid_i,
    input  disp_pkg::iid_t        eu_tag_i,
    input  logic [`NUM_WARPS-1:0] finished_i,
    output int                    err_count_o,
    output int                    disp_count_o,
    output int                    pending_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import disp_pkg::*;

    typedef struct packed {
        pc_t         pc;
        act_mask_t   mask;
        inst_t       inst;
        reg_idx_t    dst;
        op_is_reg_t  is_reg;
        op_reg_idx_t ops;
    } instr_t;

    // Accepted but not yet dispatched, per warp
    instr_t               exp_q [`NUM_WARPS][$];
    // In-flight tags and their destinations
    logic [`NUM_TAGS-1:0] busy [`NUM_WARPS];
    reg_idx_t             busy_dst [`NUM_WARPS][`NUM_TAGS];
    int                   ptr;

    task automatic mismatch(string name, int w, logic [31:0] exp_v, logic [31:0] act_v);
        err_count_o++;
        $display("[ERROR] %s warp %0d: expected %0h actual %0h", name, w, exp_v, act_v);
    endtask

    task automatic problem(string msg);
        err_count_o++;
        $display("Check failed at %0t: %s", $time, msg);
    endtask

    // Destination or register operand against in-flight writes
    function automatic bit conflicts(int w, instr_t e);
        bit hit;
        hit = 1'b0;
        for (int t = 0; t < `NUM_TAGS; t++) begin
            if (busy[w][t]) begin
                if (busy_dst[w][t] == e.dst) begin
                    hit = 1'b1;
                end
                for (int op = 0; op < `NUM_OPERANDS; op++) begin
                    if (e.is_reg[op] && (e.ops[op] == busy_dst[w][t])) begin
                        hit = 1'b1;
                    end
                end
            end
        end
        return hit;
    endfunction

    function automatic int lowest_free(int w);
        int low;
        low = -1;
        for (int t = `NUM_TAGS - 1; t >= 0; t--) begin
            if (!busy[w][t]) begin
                low = t;
            end
        end
        return low;
    endfunction

    function automatic bit warp_ready(int w);
        if (exp_q[w].size() == 0) begin
            return 1'b0;
        end
        return (lowest_free(w) >= 0) && !conflicts(w, exp_q[w][0]);
    endfunction

    always @(posedge clk_i) begin : check
        instr_t act;
        instr_t exp;
        int     w;
        int     tag;
        int     low;
        int     pred_w;
        bit     pred_v;
        bit     fire;
        bit     exp_idle;
        bit     exp_ready;
        if (rst_i) begin
            for (int i = 0; i < `NUM_WARPS; i++) begin
                exp_q[i].delete();
                busy[i] = '0;
            end
            ptr = 0;
        end else begin
            // Idle flag per warp follows the model
            for (int i = 0; i < `NUM_WARPS; i++) begin
                exp_idle = (exp_q[i].size() == 0) && (busy[i] == '0);
                if (finished_i[i] !== exp_idle) begin
                    mismatch("idle_flag", i, 32'(exp_idle), 32'(finished_i[i]));
                end
            end

            // Buffer space of the addressed warp
            exp_ready = (exp_q[int'(dec_warp_id_i)].size() < `IB_DEPTH);
            if (ib_ready_i !== exp_ready) begin
                mismatch("ib_ready", int'(dec_warp_id_i), 32'(exp_ready), 32'(ib_ready_i));
            end

            // Round-robin prediction over the warps the model sees as ready
            pred_v = 1'b0;
            pred_w = 0;
            for (int i = 0; i < `NUM_WARPS; i++) begin
                w = (ptr + i) % `NUM_WARPS;
                if (!pred_v && warp_ready(w)) begin
                    pred_v = 1'b1;
                    pred_w = w;
                end
            end
            if (disp_valid_i !== pred_v) begin
                mismatch("disp_valid", pred_w, 32'(pred_v), 32'(disp_valid_i));
            end

            fire       = disp_valid_i && opc_ready_i;
            w          = int'(disp_tag_i[WidWidth-1:0]);
            tag        = int'(disp_tag_i[WidWidth +: TagWidth]);
            low        = lowest_free(w);
            act.pc     = disp_pc_i;
            act.mask   = disp_act_mask_i;
            act.inst   = disp_inst_i;
            act.dst    = disp_dst_i;
            act.is_reg = disp_operands_is_reg_i;
            act.ops    = disp_operands_i;

            if (fire) begin
                disp_count_o++;
                if (pred_v && (w != pred_w)) begin
                    mismatch("rr_grant", w, 32'(pred_w), 32'(w));
                end
                if (exp_q[w].size() == 0) begin
                    problem($sformatf("warp %0d dispatched with nothing pending", w));
                end else begin
                    exp = exp_q[w].pop_front();
                    if (act.pc !== exp.pc) begin
                        mismatch("order_pc", w, 32'(exp.pc), 32'(act.pc));
                    end
                    if (act.mask !== exp.mask) begin
                        mismatch("order_mask", w, 32'(exp.mask), 32'(act.mask));
                    end
                    if (act.inst !== exp.inst) begin
                        mismatch("order_inst", w, 32'(exp.inst), 32'(act.inst));
                    end
                    if (act.dst !== exp.dst) begin
                        mismatch("order_dst", w, 32'(exp.dst), 32'(act.dst));
                    end
                    if ({act.is_reg, act.ops} !== {exp.is_reg, exp.ops}) begin
                        mismatch("order_operands", w, 32'({exp.is_reg, exp.ops}),
                                 32'({act.is_reg, act.ops}));
                    end
                end
                if (conflicts(w, act)) begin
                    problem($sformatf("warp %0d pc %h dispatched over a pending write", w, act.pc));
                end
                if (low < 0) begin
                    problem($sformatf("warp %0d dispatched with all tags in flight", w));
                end else if (tag != low) begin
                    mismatch("tag_alloc", w, 32'(low), 32'(tag));
                end
                ptr = (w + 1) % `NUM_WARPS;
            end

            // Writeback frees its tag, then the new tag is taken
            if (eu_valid_i) begin
                busy[int'(eu_tag_i[WidWidth-1:0])][int'(eu_tag_i[WidWidth +: TagWidth])] = 1'b0;
            end
            if (fire) begin
                busy[w][tag]     = 1'b1;
                busy_dst[w][tag] = act.dst;
            end

            if (dec_valid_i && ib_ready_i) begin
                exp.pc     = dec_pc_i;
                exp.mask   = dec_act_mask_i;
                exp.inst   = dec_inst_i;
                exp.dst    = dec_dst_i;
                exp.is_reg = dec_operands_is_reg_i;
                exp.ops    = dec_operands_i;
                exp_q[int'(dec_warp_id_i)].push_back(exp);
            end
        end

        pending_o = 0;
        for (int i = 0; i < `NUM_WARPS; i++) begin
            pending_o += exp_q[i].size();
        end
    end

endmodule

//--- sim/tb_top.sv
// Testbench top for the warp dispatch stage
// Clock, reset, stimulus from the data file and the writeback model

`include "disp_consts.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import disp_pkg::*;

    localparam int unsigned Seed          = 32'h31051d82;
    localparam int          AcceptTimeout = 200;
    localparam int          DrainTimeout  = 1000;

    typedef struct packed {
        wid_t        warp;
        pc_t         pc;
        reg_idx_t    dst;
        op_is_reg_t  is_reg;
        op_reg_idx_t ops;
    } stim_t;

    logic                  clk_i = 1'b0;
    logic                  rst_i;
    logic                  dec_valid_i;
    wid_t                  dec_warp_id_i;
    pc_t                   dec_pc_i;
    act_mask_t             dec_act_mask_i;
    inst_t                 dec_inst_i;
    reg_idx_t              dec_dst_i;
    op_is_reg_t            dec_operands_is_reg_i;
    op_reg_idx_t           dec_operands_i;
    logic                  ib_ready_o;
    logic                  opc_ready_i;
    logic                  disp_valid_o;
    iid_t                  disp_tag_o;
    pc_t                   disp_pc_o;
    act_mask_t             disp_act_mask_o;
    inst_t                 disp_inst_o;
    reg_idx_t              disp_dst_o;
    op_is_reg_t            disp_operands_is_reg_o;
    op_reg_idx_t           disp_operands_o;
    logic                  eu_valid_i;
    iid_t                  eu_tag_i;
    logic [`NUM_WARPS-1:0] ib_all_instr_finished_o;
    int                    chk_errors;
    int                    chk_dispatched;
    int                    chk_pending;

    always #5 clk_i = ~clk_i;

    multi_warp_dispatcher dut (.*);

    tb_checker i_checker (
        .clk_i                  (clk_i),
        .rst_i                  (rst_i),
        .dec_valid_i            (dec_valid_i),
        .dec_warp_id_i          (dec_warp_id_i),
        .dec_pc_i               (dec_pc_i),
        .dec_act_mask_i         (dec_act_mask_i),
        .dec_inst_i             (dec_inst_i),
        .dec_dst_i              (dec_dst_i),
        .dec_operands_is_reg_i  (dec_operands_is_reg_i),
        .dec_operands_i         (dec_operands_i),
        .ib_ready_i             (ib_ready_o),
        .disp_valid_i           (disp_valid_o),
        .opc_ready_i            (opc_ready_i),
        .disp_tag_i             (disp_tag_o),
        .disp_pc_i              (disp_pc_o),
        .disp_act_mask_i        (disp_act_mask_o),
        .disp_inst_i            (disp_inst_o),
        .disp_dst_i             (disp_dst_o),
        .disp_operands_is_reg_i (disp_operands_is_reg_o),
        .disp_operands_i        (disp_operands_o),
        .eu_valid_i             (eu_valid_i),
        .eu_tag_i               (eu_tag_i),
        .finished_i             (ib_all_instr_finished_o),
        .err_count_o            (chk_errors),
        .disp_count_o           (chk_dispatched),
        .pending_o              (chk_pending)
    );

    // ##################################################################
    // Writeback model and operand collector back-pressure
    // ##################################################################

    initial begin : writeback
        iid_t        wb_iid [$];
        int unsigned wb_due [$];
        int unsigned cycle;
        int          pick;
        void'($urandom(Seed));
        opc_ready_i = 1'b0;
        eu_valid_i  = 1'b0;
        eu_tag_i    = '0;
        cycle       = 0;
        forever begin
            @(posedge clk_i);
            cycle++;
            if (rst_i) begin
                wb_iid.delete();
                wb_due.delete();
                eu_valid_i <= 1'b0;
            end else begin
                if (disp_valid_o && opc_ready_i) begin
                    wb_iid.push_back(disp_tag_o);
                    wb_due.push_back(cycle + 1 + ($urandom % 8));
                end
                // One result per cycle, the first one that is due
                pick = -1;
                foreach (wb_due[i]) begin
                    if ((pick < 0) && (wb_due[i] <= cycle)) begin
                        pick = i;
                    end
                end
                if (pick >= 0) begin
                    eu_valid_i <= 1'b1;
                    eu_tag_i   <= wb_iid[pick];
                    wb_iid.delete(pick);
                    wb_due.delete(pick);
                end else begin
                    eu_valid_i <= 1'b0;
                end
            end
            opc_ready_i <= (($urandom % 4) != 0);
        end
    end

    // ##################################################################
    // Stimulus
    // ##################################################################

    initial begin : main
        stim_t       stim_q [$];
        stim_t       s;
        string       line;
        int          fd;
        int          waited;
        int          tb_errors;
        int          timeouts;
        bit          accepted;
        logic [31:0] f_warp, f_pc, f_dst, f_isreg, f_op0, f_op1;
        rst_i                 = 1'b1;
        dec_valid_i           = 1'b0;
        dec_warp_id_i         = '0;
        dec_pc_i              = '0;
        dec_act_mask_i        = '0;
        dec_inst_i            = '0;
        dec_dst_i             = '0;
        dec_operands_is_reg_i = '0;
        dec_operands_i        = '0;
        tb_errors             = 0;
        timeouts              = 0;

        fd = $fopen("sim/dispatch_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/dispatch_stimulus.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ((line.len() > 0) && (line.getc(0) != "#")) begin
                    if ($sscanf(line, "%h %h %h %h %h %h",
                                f_warp, f_pc, f_dst, f_isreg, f_op0, f_op1) == 6) begin
                        s.warp   = wid_t'(f_warp);
                        s.pc     = pc_t'(f_pc);
                        s.dst    = reg_idx_t'(f_dst);
                        s.is_reg = op_is_reg_t'(f_isreg);
                        s.ops    = {reg_idx_t'(f_op1), reg_idx_t'(f_op0)};
                        stim_q.push_back(s);
                    end
                end
            end
            $fclose(fd);
        end
        if (stim_q.size() == 0) begin
            $display("No instructions were read from the stimulus file");
            tb_errors++;
        end

        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;

        // Each line is held on the decoder port until the DUT takes it
        foreach (stim_q[i]) begin
            if (timeouts == 0) begin
                dec_valid_i           <= 1'b1;
                dec_warp_id_i         <= stim_q[i].warp;
                dec_pc_i              <= stim_q[i].pc;
                dec_act_mask_i        <= act_mask_t'(stim_q[i].pc >> 2);
                dec_inst_i            <= stim_q[i].pc ^ 16'h5a5a;
                dec_dst_i             <= stim_q[i].dst;
                dec_operands_is_reg_i <= stim_q[i].is_reg;
                dec_operands_i        <= stim_q[i].ops;
                accepted = 1'b0;
                waited   = 0;
                while (!accepted && (timeouts == 0)) begin
                    @(posedge clk_i);
                    waited++;
                    if (ib_ready_o) begin
                        accepted = 1'b1;
                    end else if (waited >= AcceptTimeout) begin
                        $display("Timeout: warp %0d pc %h was never accepted",
                                 stim_q[i].warp, stim_q[i].pc);
                        timeouts++;
                    end
                end
            end
        end
        dec_valid_i <= 1'b0;

        // Drain until every warp is idle again
        waited = 0;
        while ((timeouts == 0) && (ib_all_instr_finished_o != '1)) begin
            @(posedge clk_i);
            waited++;
            if (waited >= DrainTimeout) begin
                $display("Timeout: warps did not become idle, idle flags %b",
                         ib_all_instr_finished_o);
                timeouts++;
            end
        end

        @(negedge clk_i);
        if (timeouts == 0) begin
            if (chk_dispatched != stim_q.size()) begin
                $display("Dispatched %0d instructions but %0d were issued",
                         chk_dispatched, stim_q.size());
                tb_errors++;
            end
            if (chk_pending != 0) begin
                $display("%0d accepted instructions were never dispatched", chk_pending);
                tb_errors++;
            end
        end

        $display("Errors: %0d checker, %0d testbench, %0d timeouts",
                 chk_errors, tb_errors, timeouts);
        if ((chk_errors == 0) && (tb_errors == 0) && (timeouts == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sim/dispatch_stimulus.txt
# Columns in hex: warp pc dst is_reg op0 op1
# Bit 0 of is_reg marks op0 as a register, bit 1 marks op1
0 0100 01 3 02 03
1 0200 04 3 05 06
0 0104 02 3 01 03
2 0300 07 1 08 1f
0 0108 01 0 00 00
3 0400 0a 3 0a 0b
1 0204 04 2 00 04
2 0304 09 3 07 07
3 0404 0c 3 0a 0c
1 0208 10 3 11 12
1 020c 13 3 14 15
1 0210 16 3 17 18
1 0214 19 0 04 04
2 0308 07 3 09 09
0 010c 05 3 02 01
3 0408 0d 1 0c 00
2 030c 1e 3 1d 1c
0 0110 06 3 06 06

//--- filelist.f
+incdir+common
common/disp_pkg.sv
dispatcher/warp_dispatcher.sv
dispatcher/rr_arbiter.sv
src/multi_warp_dispatcher.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- Makefile
# Verilator flow for the warp dispatch stage

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  ?= >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
